//--- tomasulo_pkg.sv
package tomasulo_pkg;

   localparam int DATA_W      = 32;
   localparam int TAG_W       = 6;

   // Execution latencies in cycles from start to result_valid
   localparam int MULT_LAT    = 3;
   localparam int DIV_LAT     = 6;

   // Word index is taken from address bits 9:2
   localparam int CACHE_AW    = 8;
   localparam int CACHE_DEPTH = 256;

   // One bit per future CDB cycle, far enough ahead to cover a division
   localparam int RSV_W       = DIV_LAT + 1;

   localparam int DIV_CNT_W   = $clog2(DIV_LAT + 1);

   // Integer opcodes follow the MIPS function field encoding
   typedef enum logic [5:0] {
      ALU_BEQ = 6'h04,
      ALU_BNE = 6'h05,
      ALU_ADD = 6'h20,
      ALU_SUB = 6'h22,
      ALU_AND = 6'h24,
      ALU_OR  = 6'h25,
      ALU_XOR = 6'h26,
      ALU_SLT = 6'h2a
   } alu_op_e;

   typedef enum logic {
      LS_LOAD  = 1'b0,
      LS_STORE = 1'b1
   } ls_op_e;

endpackage

//--- int_alu.sv
`timescale 1ns/1ps

module int_alu (
   input  tomasulo_pkg::alu_op_e             op,
   input  logic [tomasulo_pkg::DATA_W-1:0]   rs,
   input  logic [tomasulo_pkg::DATA_W-1:0]   rt,
   output logic [tomasulo_pkg::DATA_W-1:0]   result,
   output logic                              carry,
   output logic                              overflow,
   output logic                              branch,
   output logic                              branch_taken
);
   import tomasulo_pkg::*;

   logic [DATA_W:0] sum;
   logic [DATA_W:0] diff;
   logic            signed_lt;
   logic            equal;

   // Extra top bit holds the carry out of the add and the borrow of the subtract
   assign sum       = {1'b0, rs} + {1'b0, rt};
   assign diff      = {1'b0, rs} - {1'b0, rt};
   assign signed_lt = $signed(rs) < $signed(rt);
   assign equal     = (rs == rt);

   always_comb begin
      result       = '0;
      carry        = 1'b0;
      overflow     = 1'b0;
      branch       = 1'b0;
      branch_taken = 1'b0;
      case (op)
         ALU_ADD: begin
            result   = sum[DATA_W-1:0];
            carry    = sum[DATA_W];
            overflow = (rs[DATA_W-1] == rt[DATA_W-1]) &&
                       (sum[DATA_W-1] != rs[DATA_W-1]);
         end
         ALU_SUB: begin
            result   = diff[DATA_W-1:0];
            // Carry reports a borrow, set when rs is below rt unsigned
            carry    = diff[DATA_W];
            overflow = (rs[DATA_W-1] != rt[DATA_W-1]) &&
                       (diff[DATA_W-1] != rs[DATA_W-1]);
         end
         ALU_AND: result = rs & rt;
         ALU_OR:  result = rs | rt;
         ALU_XOR: result = rs ^ rt;
         ALU_SLT: result = {{(DATA_W-1){1'b0}}, signed_lt};
         ALU_BEQ: begin
            branch       = 1'b1;
            branch_taken = equal;
         end
         ALU_BNE: begin
            branch       = 1'b1;
            branch_taken = ~equal;
         end
         default: result = '0;
      endcase
   end

endmodule

//--- mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              start,
   input  logic [tomasulo_pkg::DATA_W-1:0]   rs,
   input  logic [tomasulo_pkg::DATA_W-1:0]   rt,
   input  logic [tomasulo_pkg::TAG_W-1:0]    tag_in,
   output logic                              result_valid,
   output logic [tomasulo_pkg::DATA_W-1:0]   result,
   output logic [tomasulo_pkg::TAG_W-1:0]    tag_out
);
   import tomasulo_pkg::*;

   logic [MULT_LAT-1:0] vld_q;
   logic [DATA_W-1:0]   prod_q [MULT_LAT];
   logic [TAG_W-1:0]    tag_q  [MULT_LAT];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[MULT_LAT-2:0], start};
      end
   end

   // Only the low word of the product is kept
   always_ff @(posedge clk) begin
      prod_q[0] <= rs * rt;
      tag_q[0]  <= tag_in;
      for (int i = 1; i < MULT_LAT; i++) begin
         prod_q[i] <= prod_q[i-1];
         tag_q[i]  <= tag_q[i-1];
      end
   end

   assign result_valid = vld_q[MULT_LAT-1];
   assign result       = prod_q[MULT_LAT-1];
   assign tag_out      = tag_q[MULT_LAT-1];

endmodule

//--- div_unit.sv
`timescale 1ns/1ps

module div_unit (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              start,
   input  logic [tomasulo_pkg::DATA_W-1:0]   rs,
   input  logic [tomasulo_pkg::DATA_W-1:0]   rt,
   input  logic [tomasulo_pkg::TAG_W-1:0]    tag_in,
   output logic                              busy,
   output logic                              result_valid,
   output logic [tomasulo_pkg::DATA_W-1:0]   result,
   output logic [tomasulo_pkg::TAG_W-1:0]    tag_out
);
   import tomasulo_pkg::*;

   logic                 active_q;
   logic [DIV_CNT_W-1:0] cnt_q;
   logic [DATA_W-1:0]    rs_q;
   logic [DATA_W-1:0]    rt_q;
   logic [TAG_W-1:0]     tag_q;
   logic                 last;

   // Counter runs 1..DIV_LAT, the final count is the result cycle
   assign last = active_q && (cnt_q == DIV_CNT_W'(DIV_LAT));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         active_q <= 1'b0;
         cnt_q    <= '0;
      end else if (start) begin
         active_q <= 1'b1;
         cnt_q    <= DIV_CNT_W'(1);
      end else if (last) begin
         active_q <= 1'b0;
      end else if (active_q) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         rs_q  <= rs;
         rt_q  <= rt;
         tag_q <= tag_in;
      end
   end

   // Busy drops in the result cycle so the next division can start then
   assign busy         = active_q && !last;
   assign result_valid = last;
   assign tag_out      = tag_q;

   // Divide by zero returns all ones
   always_comb begin
      if (rt_q == '0) begin
         result = '1;
      end else begin
         result = rs_q / rt_q;
      end
   end

endmodule

//--- data_cache.sv
`timescale 1ns/1ps

module data_cache (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              wen,
   input  logic [tomasulo_pkg::DATA_W-1:0]   addr,
   input  logic [tomasulo_pkg::DATA_W-1:0]   wdata,
   output logic [tomasulo_pkg::DATA_W-1:0]   rdata
);
   import tomasulo_pkg::*;

   logic [DATA_W-1:0]   mem [CACHE_DEPTH];
   logic [CACHE_AW-1:0] idx;

   // Word addressed, byte offset bits ignored
   assign idx = addr[CACHE_AW+1:2];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < CACHE_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (wen) begin
         mem[idx] <= wdata;
      end
   end

   assign rdata = mem[idx];

endmodule

//--- issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
   input  logic                              clk,
   input  logic                              rst_n,

   input  logic                              int_ready,
   input  tomasulo_pkg::alu_op_e             int_op,
   input  logic [tomasulo_pkg::DATA_W-1:0]   int_rs,
   input  logic [tomasulo_pkg::DATA_W-1:0]   int_rt,
   input  logic [tomasulo_pkg::TAG_W-1:0]    int_tag,
   output logic                              int_done,

   input  logic                              mult_ready,
   input  logic [tomasulo_pkg::DATA_W-1:0]   mult_rs,
   input  logic [tomasulo_pkg::DATA_W-1:0]   mult_rt,
   input  logic [tomasulo_pkg::TAG_W-1:0]    mult_tag,
   output logic                              mult_done,

   input  logic                              div_ready,
   input  logic [tomasulo_pkg::DATA_W-1:0]   div_rs,
   input  logic [tomasulo_pkg::DATA_W-1:0]   div_rt,
   input  logic [tomasulo_pkg::TAG_W-1:0]    div_tag,
   output logic                              div_done,

   input  logic                              ls_ready,
   input  tomasulo_pkg::ls_op_e              ls_op,
   input  logic [tomasulo_pkg::DATA_W-1:0]   ls_addr,
   input  logic [tomasulo_pkg::DATA_W-1:0]   ls_data,
   input  logic [tomasulo_pkg::TAG_W-1:0]    ls_tag,
   output logic                              ls_done,

   output logic                              cdb_valid,
   output logic [tomasulo_pkg::DATA_W-1:0]   cdb_data,
   output logic [tomasulo_pkg::TAG_W-1:0]    cdb_tag,
   output logic                              cdb_branch,
   output logic                              cdb_branch_taken,
   output logic                              cdb_carry,
   output logic                              cdb_overflow
);
   import tomasulo_pkg::*;

   // Bit k set means the CDB register is already claimed k+1 cycles ahead
   logic [RSV_W-1:0]  rsv_q;
   logic [RSV_W-1:0]  rsv_set;
   logic [RSV_W-1:0]  rsv_now;
   logic              ls_first_q;
   logic              slot_free;
   logic              contend;
   logic              load_go;
   logic              store_go;

   logic [DATA_W-1:0] alu_result;
   logic              alu_carry;
   logic              alu_overflow;
   logic              alu_branch;
   logic              alu_taken;

   logic              mult_valid;
   logic [DATA_W-1:0] mult_result;
   logic [TAG_W-1:0]  mult_tag_out;

   logic              div_busy;
   logic              div_valid;
   logic [DATA_W-1:0] div_result;
   logic [TAG_W-1:0]  div_tag_out;

   logic [DATA_W-1:0] cache_rdata;

   logic              nxt_valid;
   logic [DATA_W-1:0] nxt_data;
   logic [TAG_W-1:0]  nxt_tag;
   logic              nxt_branch;
   logic              nxt_taken;
   logic              nxt_carry;
   logic              nxt_overflow;

   assign slot_free = ~rsv_q[0];
   assign contend   = int_ready & ls_ready & slot_free;

   // Division lands last and is never blocked by an earlier reservation
   assign div_done  = div_ready & ~div_busy;
   assign mult_done = mult_ready & ~rsv_q[MULT_LAT];
   assign int_done  = int_ready & slot_free & (~ls_ready | ~ls_first_q);
   assign ls_done   = ls_ready & slot_free & (~int_ready | ls_first_q);

   assign load_go   = ls_done & (ls_op == LS_LOAD);
   assign store_go  = ls_done & (ls_op == LS_STORE);

   always_comb begin
      rsv_set          = '0;
      rsv_set[DIV_LAT]  = div_done;
      rsv_set[MULT_LAT] = mult_done;
      rsv_set[0]        = int_done | load_go;
   end

   assign rsv_now = rsv_q | rsv_set;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsv_q      <= '0;
         ls_first_q <= 1'b0;
      end else begin
         rsv_q <= {1'b0, rsv_now[RSV_W-1:1]};
         if (contend) begin
            ls_first_q <= ~ls_first_q;
         end
      end
   end

   // Sources are mutually exclusive through the reservation register
   always_comb begin
      nxt_valid    = 1'b0;
      nxt_data     = '0;
      nxt_tag      = '0;
      nxt_branch   = 1'b0;
      nxt_taken    = 1'b0;
      nxt_carry    = 1'b0;
      nxt_overflow = 1'b0;
      if (int_done) begin
         nxt_valid    = 1'b1;
         nxt_data     = alu_result;
         nxt_tag      = int_tag;
         nxt_branch   = alu_branch;
         nxt_taken    = alu_taken;
         nxt_carry    = alu_carry;
         nxt_overflow = alu_overflow;
      end else if (load_go) begin
         nxt_valid = 1'b1;
         nxt_data  = cache_rdata;
         nxt_tag   = ls_tag;
      end else if (mult_valid) begin
         nxt_valid = 1'b1;
         nxt_data  = mult_result;
         nxt_tag   = mult_tag_out;
      end else if (div_valid) begin
         nxt_valid = 1'b1;
         nxt_data  = div_result;
         nxt_tag   = div_tag_out;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cdb_valid <= 1'b0;
      end else begin
         cdb_valid <= nxt_valid;
      end
   end

   always_ff @(posedge clk) begin
      cdb_data         <= nxt_data;
      cdb_tag          <= nxt_tag;
      cdb_branch       <= nxt_branch;
      cdb_branch_taken <= nxt_taken;
      cdb_carry        <= nxt_carry;
      cdb_overflow     <= nxt_overflow;
   end

   int_alu u_int_alu (
      .op           (int_op),
      .rs           (int_rs),
      .rt           (int_rt),
      .result       (alu_result),
      .carry        (alu_carry),
      .overflow     (alu_overflow),
      .branch       (alu_branch),
      .branch_taken (alu_taken)
   );

   mult_pipe u_mult_pipe (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (mult_done),
      .rs           (mult_rs),
      .rt           (mult_rt),
      .tag_in       (mult_tag),
      .result_valid (mult_valid),
      .result       (mult_result),
      .tag_out      (mult_tag_out)
   );

   div_unit u_div_unit (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (div_done),
      .rs           (div_rs),
      .rt           (div_rt),
      .tag_in       (div_tag),
      .busy         (div_busy),
      .result_valid (div_valid),
      .result       (div_result),
      .tag_out      (div_tag_out)
   );

   // A granted store writes at the end of its grant cycle
   data_cache u_data_cache (
      .clk          (clk),
      .rst_n        (rst_n),
      .wen          (store_go),
      .addr         (ls_addr),
      .wdata        (ls_data),
      .rdata        (cache_rdata)
   );

endmodule

//--- issue_stage_properties.sv
`timescale 1ns/1ps

module issue_stage_properties (
   input logic clk,
   input logic rst_n,
   input logic int_ready,
   input logic int_done,
   input logic mult_ready,
   input logic mult_done,
   input logic div_ready,
   input logic div_done,
   input logic ls_ready,
   input logic ls_done,
   input logic load_go,
   input logic mult_valid,
   input logic div_valid,
   input logic cdb_valid
);
   import tomasulo_pkg::*;

   logic [3:0]           src;
   logic [DIV_CNT_W-1:0] div_left;

   // Every source that feeds the CDB register in a cycle
   assign src = {int_done, load_go, mult_valid, div_valid};

   // Cycles the divider stays occupied after a start
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         div_left <= '0;
      end else if (div_done) begin
         div_left <= DIV_CNT_W'(DIV_LAT - 1);
      end else if (div_left != '0) begin
         div_left <= div_left - 1'b1;
      end
   end

   a_done_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
      ({int_done, mult_done, div_done, ls_done} &
       ~{int_ready, mult_ready, div_ready, ls_ready}) == 4'b0000)
      else $error("done strobe raised without ready");

   a_int_ls_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(int_done && ls_done))
      else $error("int_done and ls_done high together");

   a_cdb_one_source: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(src))
      else $error("two results compete for the CDB in one cycle");

   // Each entry traces back to one grant at its unit's latency
   a_cdb_valid_per_grant: assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid |-> ($past(int_done) || $past(load_go) ||
                     $past(mult_done, MULT_LAT + 1) || $past(div_done, DIV_LAT + 1)))
      else $error("cdb_valid high without a grant behind it");

   a_div_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
      div_done |-> (div_left == '0))
      else $error("div_done while the divider is busy");

endmodule

bind issue_stage issue_stage_properties u_props (
   .clk        (clk),
   .rst_n      (rst_n),
   .int_ready  (int_ready),
   .int_done   (int_done),
   .mult_ready (mult_ready),
   .mult_done  (mult_done),
   .div_ready  (div_ready),
   .div_done   (div_done),
   .ls_ready   (ls_ready),
   .ls_done    (ls_done),
   .load_go    (load_go),
   .mult_valid (mult_valid),
   .div_valid  (div_valid),
   .cdb_valid  (cdb_valid)
);

//--- tb_issue_stage.sv
`timescale 1ns/1ps

module tb_issue_stage;
   import tomasulo_pkg::*;

   logic              clk;
   logic              rst_n;
   logic              int_ready;
   alu_op_e           int_op;
   logic [DATA_W-1:0] int_rs;
   logic [DATA_W-1:0] int_rt;
   logic [TAG_W-1:0]  int_tag;
   logic              int_done;
   logic              mult_ready;
   logic [DATA_W-1:0] mult_rs;
   logic [DATA_W-1:0] mult_rt;
   logic [TAG_W-1:0]  mult_tag;
   logic              mult_done;
   logic              div_ready;
   logic [DATA_W-1:0] div_rs;
   logic [DATA_W-1:0] div_rt;
   logic [TAG_W-1:0]  div_tag;
   logic              div_done;
   logic              ls_ready;
   ls_op_e            ls_op;
   logic [DATA_W-1:0] ls_addr;
   logic [DATA_W-1:0] ls_data;
   logic [TAG_W-1:0]  ls_tag;
   logic              ls_done;
   logic              cdb_valid;
   logic [DATA_W-1:0] cdb_data;
   logic [TAG_W-1:0]  cdb_tag;
   logic              cdb_branch;
   logic              cdb_branch_taken;
   logic              cdb_carry;
   logic              cdb_overflow;

   // Outstanding results by tag, word is {branch, taken, carry, overflow, data}
   logic [(1<<TAG_W)-1:0] exp_pend;
   logic [DATA_W+3:0]     exp_word [1<<TAG_W];
   int                    exp_cyc  [1<<TAG_W];
   logic [DATA_W-1:0]     ref_mem  [CACHE_DEPTH];
   int                    grant_cyc [4];
   int                    grant_log [$];
   int                    cycle = 0;
   int                    tag_cnt = 0;
   int                    checks = 0;
   int                    errors = 0;
   int                    timeouts = 0;
   integer                seed = 32'h55e86db4;

   issue_stage UUT (.*);

   always #4 clk = ~clk;

   always @(posedge clk) cycle <= cycle + 1;

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Matches every broadcast against an outstanding tag
   always @(negedge clk) begin
      if (rst_n && cdb_valid) begin
         if (!exp_pend[cdb_tag]) begin
            errors++;
            $display("error at %0t: broadcast of tag %0d that no operation expects",
                     $time, cdb_tag);
         end else begin
            check($sformatf("tag %0d result", cdb_tag),
                  64'({cdb_branch, cdb_branch_taken, cdb_carry, cdb_overflow, cdb_data}),
                  64'(exp_word[cdb_tag]));
            check($sformatf("tag %0d arrival cycle", cdb_tag), 64'(cycle),
                  64'(exp_cyc[cdb_tag]));
            exp_pend[cdb_tag] = 1'b0;
         end
      end
   end

   function automatic logic [DATA_W+3:0] alu_model(input alu_op_e op,
                                                  input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
      longint            sa;
      longint            sb;
      logic [DATA_W-1:0] d;
      logic              br;
      logic              tk;
      logic              cy;
      logic              ov;
      sa = longint'($signed(a));
      sb = longint'($signed(b));
      d  = '0;
      br = 1'b0;
      tk = 1'b0;
      cy = 1'b0;
      ov = 1'b0;
      case (op)
         ALU_ADD: begin
            d  = a + b;
            cy = (64'(a) + 64'(b)) != 64'(d);
            // Signed overflow when the exact sum does not fit the result
            ov = (sa + sb) != longint'($signed(d));
         end
         ALU_SUB: begin
            d  = a - b;
            cy = a < b;
            ov = (sa - sb) != longint'($signed(d));
         end
         ALU_AND: d = a & b;
         ALU_OR:  d = a | b;
         ALU_XOR: d = a ^ b;
         ALU_SLT: d = DATA_W'(sa < sb);
         ALU_BEQ: begin
            br = 1'b1;
            tk = a == b;
         end
         ALU_BNE: begin
            br = 1'b1;
            tk = a != b;
         end
         default: d = '0;
      endcase
      return {br, tk, cy, ov, d};
   endfunction

   function automatic logic [TAG_W-1:0] new_tag();
      logic [TAG_W-1:0] t;
      t = TAG_W'(tag_cnt);
      tag_cnt++;
      return t;
   endfunction

   function automatic logic done_of(input int q);
      case (q)
         0:       return int_done;
         1:       return mult_done;
         2:       return div_done;
         default: return ls_done;
      endcase
   endfunction

   task automatic expect_result(input logic [TAG_W-1:0] tag, input logic [DATA_W+3:0] word,
                                input int lat);
      exp_pend[tag] = 1'b1;
      exp_word[tag] = word;
      exp_cyc[tag]  = cycle + lat;
   endtask

   // Queue index 0 int, 1 mult, 2 div, 3 load/store
   task automatic wait_grant(input int q);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!done_of(q) && n < 100);
      if (!done_of(q)) begin
         timeouts++;
         $display("timeout: queue %0d was never granted", q);
      end
      grant_cyc[q] = cycle;
      grant_log.push_back(q);
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_pend != '0 && n < 100) begin
         @(posedge clk);
         n++;
      end
      if (exp_pend != '0) begin
         timeouts++;
         $display("timeout: no CDB result for pending tags %h", exp_pend);
      end
   endtask

   task automatic apply_reset();
      rst_n <= 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      exp_pend = '0;
      foreach (ref_mem[i]) ref_mem[i] = '0;
   endtask

   // Issue tasks start and end right after a rising edge and leave ready high
   task automatic issue_int(input alu_op_e op, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b);
      logic [TAG_W-1:0] t;
      t = new_tag();
      int_ready <= 1'b1;
      int_op    <= op;
      int_rs    <= a;
      int_rt    <= b;
      int_tag   <= t;
      wait_grant(0);
      expect_result(t, alu_model(op, a, b), 1);
      @(posedge clk);
   endtask

   task automatic issue_mult(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
      logic [TAG_W-1:0] t;
      t = new_tag();
      mult_ready <= 1'b1;
      mult_rs    <= a;
      mult_rt    <= b;
      mult_tag   <= t;
      wait_grant(1);
      expect_result(t, {4'h0, DATA_W'(64'(a) * 64'(b))}, MULT_LAT + 1);
      @(posedge clk);
   endtask

   task automatic issue_div(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
      logic [TAG_W-1:0] t;
      t = new_tag();
      div_ready <= 1'b1;
      div_rs    <= a;
      div_rt    <= b;
      div_tag   <= t;
      wait_grant(2);
      expect_result(t, {4'h0, (b == '0) ? {DATA_W{1'b1}} : a / b}, DIV_LAT + 1);
      @(posedge clk);
   endtask

   task automatic issue_ls(input ls_op_e op, input logic [DATA_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
      logic [TAG_W-1:0] t;
      t = new_tag();
      ls_ready <= 1'b1;
      ls_op    <= op;
      ls_addr  <= addr;
      ls_data  <= data;
      ls_tag   <= t;
      wait_grant(3);
      if (op == LS_STORE) begin
         ref_mem[addr[9:2]] = data;
      end else begin
         expect_result(t, {4'h0, ref_mem[addr[9:2]]}, 1);
      end
      @(posedge clk);
   endtask

   task automatic test_alu();
      issue_int(ALU_ADD, 32'h7fff_ffff, 32'h0000_0001);
      issue_int(ALU_ADD, 32'hffff_ffff, 32'h0000_0001);
      issue_int(ALU_SUB, 32'h0000_0000, 32'h0000_0001);
      issue_int(ALU_SUB, 32'h8000_0000, 32'h0000_0001);
      issue_int(ALU_AND, 32'hf0f0_1234, 32'h0ff0_ffff);
      issue_int(ALU_OR,  32'hf0f0_1234, 32'h0ff0_0001);
      issue_int(ALU_XOR, 32'hffff_0000, 32'h0ff0_0ff0);
      issue_int(ALU_SLT, 32'hffff_ffff, 32'h0000_0001);
      issue_int(ALU_SLT, 32'h0000_0001, 32'hffff_ffff);
      issue_int(ALU_BEQ, 32'h1234_5678, 32'h1234_5678);
      issue_int(ALU_BNE, 32'h1234_5678, 32'h1234_5678);
      issue_int(ALU_BEQ, 32'h0000_0001, 32'h0000_0002);
      issue_int(ALU_BNE, 32'h0000_0001, 32'h0000_0002);
      int_ready <= 1'b0;
      drain();
   endtask

   task automatic test_mult();
      int g0;
      issue_mult($random(seed), $random(seed));
      g0 = grant_cyc[1];
      issue_mult(32'hffff_ffff, 32'hffff_ffff);
      issue_mult(32'h0001_0000, 32'h0001_0003);
      mult_ready <= 1'b0;
      check("third mult grant cycle", 64'(grant_cyc[1] - g0), 64'd2);
      drain();
   endtask

   task automatic test_div();
      int g0;
      issue_div(32'd1000, 32'd7);
      g0 = grant_cyc[2];
      issue_div(32'hffff_fff0, 32'd3);
      check("second div grant delay", 64'(grant_cyc[2] - g0), 64'(DIV_LAT));
      issue_div(32'd55, 32'd0);
      div_ready <= 1'b0;
      drain();
   endtask

   task automatic test_ls();
      issue_ls(LS_STORE, 32'h0000_0040, 32'hcafe_f00d);
      issue_ls(LS_LOAD,  32'h0000_0040, 32'h0);
      issue_ls(LS_LOAD,  32'h0000_0080, 32'h0);
      ls_ready <= 1'b0;
      drain();
   endtask

   task automatic test_arbitration();
      apply_reset();
      grant_log.delete();
      fork
         begin
            repeat (4) issue_int(ALU_XOR, $random(seed), $random(seed));
            int_ready <= 1'b0;
         end
         begin
            repeat (4) issue_ls(LS_LOAD, {26'd0, 4'($random(seed)), 2'b00}, 32'h0);
            ls_ready <= 1'b0;
         end
      join
      check("grant count", 64'(grant_log.size()), 64'd8);
      foreach (grant_log[i]) check("grant order", 64'(grant_log[i]), (i % 2 == 1) ? 64'd3 : 64'd0);
      drain();
      // Int raised three cycles after a mult must skip the mult's CDB cycle
      fork
         begin
            issue_mult($random(seed), $random(seed));
            mult_ready <= 1'b0;
         end
         begin
            repeat (3) @(posedge clk);
            issue_int(ALU_ADD, 32'd1, 32'd2);
            int_ready <= 1'b0;
         end
      join
      check("int grant after mult", 64'(grant_cyc[0] - grant_cyc[1]), 64'd4);
      drain();
      fork
         begin
            issue_div(32'd99, 32'd9);
            div_ready <= 1'b0;
         end
         begin
            repeat (3) @(posedge clk);
            issue_mult(32'd6, 32'd7);
            mult_ready <= 1'b0;
         end
      join
      check("mult grant after div", 64'(grant_cyc[1] - grant_cyc[2]), 64'd4);
      drain();
   endtask

   task automatic test_random();
      alu_op_e ops [8] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                           ALU_XOR, ALU_SLT, ALU_BEQ, ALU_BNE};
      fork
         begin
            repeat (12) issue_int(ops[3'($random(seed))], $random(seed), $random(seed));
            int_ready <= 1'b0;
         end
         begin
            repeat (12) issue_mult($random(seed), $random(seed));
            mult_ready <= 1'b0;
         end
         begin
            repeat (6) issue_div($random(seed), {29'd0, 3'($random(seed))});
            div_ready <= 1'b0;
         end
         begin
            repeat (12) issue_ls(ls_op_e'(1'($random(seed))),
                                 {27'd0, 3'($random(seed)), 2'b00}, $random(seed));
            ls_ready <= 1'b0;
         end
      join
      drain();
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      int_ready  = 1'b0;
      int_op     = ALU_ADD;
      int_rs     = '0;
      int_rt     = '0;
      int_tag    = '0;
      mult_ready = 1'b0;
      mult_rs    = '0;
      mult_rt    = '0;
      mult_tag   = '0;
      div_ready  = 1'b0;
      div_rs     = '0;
      div_rt     = '0;
      div_tag    = '0;
      ls_ready   = 1'b0;
      ls_op      = LS_LOAD;
      ls_addr    = '0;
      ls_data    = '0;
      ls_tag     = '0;
      apply_reset();
      @(negedge clk);
      check("strobes after reset",
            64'({int_done, mult_done, div_done, ls_done, cdb_valid, UUT.div_busy}), 64'd0);
      @(posedge clk);
      test_alu();
      test_mult();
      test_div();
      test_ls();
      test_arbitration();
      test_random();
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- issue_stage.f
tomasulo_pkg.sv
int_alu.sv
mult_pipe.sv
div_unit.sv
data_cache.sv
issue_stage.sv
issue_stage_properties.sv
tb_issue_stage.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_issue_stage
FILELIST  := issue_stage.f
OBJDIR    := obj_dir
SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJDIR)
